// ==== hw/fmaPkg.sv ====
// Shared types and constants for the half-precision FMA
// Format widths, special encodings, rounding-mode codes, flag bit positions
package fmaPkg;

    // Binary16 word and its fields
    typedef logic [15:0] halfWordT;
    typedef logic [4:0]  expT;
    typedef logic [10:0] sigT;

    // Intermediate datapath widths
    typedef logic [5:0]  productExpT;
    typedef logic [21:0] productSigT;
    typedef logic [23:0] sumSigT;

    typedef logic [1:0]  roundModeT;
    typedef logic [3:0]  flagsT;

    localparam expT      expBias            = 5'd15;
    localparam expT      expAllOnes         = 5'd31;
    localparam expT      maxFiniteExp       = 5'd30;

    // Positive quiet NaN
    localparam halfWordT canonicalNan       = 16'h7E00;
    localparam halfWordT infMagnitude       = 16'h7C00;
    localparam halfWordT maxFiniteMagnitude = 16'h7BFF;

    localparam roundModeT roundTowardZero  = 2'd0;
    localparam roundModeT roundNearestEven = 2'd1;
    localparam roundModeT roundDown        = 2'd2;
    localparam roundModeT roundUp          = 2'd3;

    localparam int flagInvalid   = 3;
    localparam int flagOverflow  = 2;
    localparam int flagUnderflow = 1;
    localparam int flagInexact   = 0;

endpackage

// ==== hw/fmaIfs.sv ====
// Interfaces between the FMA stages
// operandIf: decoded operands, productIf: multiplier output, sumIf: aligned sum
`timescale 1ns/1ps

interface operandIf import fmaPkg::*; ();
    logic signA, signB, signC;
    expT  expA, expB, expC;
    sigT  sigA, sigB, sigC;
    logic nanA, nanB, nanC;
    logic snanA, snanB, snanC;
    logic productOperandInf;
    logic productInputZero;
    // Exponent of C is all ones, so C is infinity or NaN
    logic cIsInf;
    logic cMantisaNonZero;

    modport decoder (
        output signA, signB, signC, expA, expB, expC, sigA, sigB, sigC,
               nanA, nanB, nanC, snanA, snanB, snanC,
               productOperandInf, productInputZero, cIsInf, cMantisaNonZero
    );
    modport datapath (
        input signA, signB, signC, expA, expB, expC, sigA, sigB, sigC,
              productOperandInf, productInputZero
    );
    modport special (
        input signC, nanA, nanB, nanC, snanA, snanB, snanC,
              productOperandInf, productInputZero, cIsInf, cMantisaNonZero
    );
endinterface

interface productIf import fmaPkg::*; ();
    logic       productSign;
    productExpT productExp;
    productSigT productSig;
    logic       productExpNegative;
    logic       productExpOverflow;

    modport driver (output productSign, productExp, productSig,
                    productExpNegative, productExpOverflow);
    modport reader (input productSign, productExp, productSig,
                    productExpNegative, productExpOverflow);
endinterface

interface sumIf import fmaPkg::*; ();
    logic   sumSign;
    expT    sumExp;
    sumSigT sumSig;
    logic   sumSubtraction;
    logic   stickyA, stickyB;

    modport driver (output sumSign, sumExp, sumSig, sumSubtraction, stickyA, stickyB);
    modport reader (input sumSign, sumExp, sumSig, sumSubtraction, stickyA, stickyB);
endinterface

// ==== hw/operandDecoder.sv ====
// Operand decoder
// Applies the mul/add enables and classifies operands as zero, infinity or NaN
`timescale 1ns/1ps

module operandDecoder import fmaPkg::*; (
    input  halfWordT operandA,
    input  halfWordT operandB,
    input  halfWordT operandC,
    input  logic     mul,
    input  logic     add,
    operandIf.decoder ops
);
    halfWordT effB, effC;

    function automatic logic isNan(input halfWordT w);
        return (w[14:10] == expAllOnes) & (|w[9:0]);
    endfunction

    function automatic logic isZero(input halfWordT w);
        return ~(|w[14:0]);
    endfunction

    // B becomes 1.0 for a plain add, C becomes +0 for a plain multiply
    assign effB = mul ? operandB : {1'b0, expBias, 10'b0};
    assign effC = add ? operandC : '0;

    assign ops.signA = operandA[15];
    assign ops.signB = effB[15];
    assign ops.signC = effC[15];

    assign ops.expA  = operandA[14:10];
    assign ops.expB  = effB[14:10];
    assign ops.expC  = effC[14:10];

    // No subnormals, so A and B always carry a hidden one
    assign ops.sigA  = {1'b1, operandA[9:0]};
    assign ops.sigB  = {1'b1, effB[9:0]};
    assign ops.sigC  = {~isZero(effC), effC[9:0]};

    assign ops.nanA  = isNan(operandA);
    assign ops.nanB  = isNan(effB);
    assign ops.nanC  = isNan(effC);

    // Signaling when the quiet bit is clear
    assign ops.snanA = isNan(operandA) & ~operandA[9];
    assign ops.snanB = isNan(effB) & ~effB[9];
    assign ops.snanC = isNan(effC) & ~effC[9];

    assign ops.productOperandInf = (operandA[14:10] == expAllOnes) | (effB[14:10] == expAllOnes);
    assign ops.productInputZero  = isZero(operandA) | isZero(effB);
    assign ops.cIsInf            = (effC[14:10] == expAllOnes);
    assign ops.cMantisaNonZero   = |effC[9:0];

endmodule

// ==== hw/multiplier.sv ====
// Significand multiplier
// Product sign, rebiased exponent and full 22-bit significand product
`timescale 1ns/1ps

module multiplier import fmaPkg::*; (
    operandIf.datapath ops,
    productIf.driver   prod
);
    productExpT expSum;
    productExpT rebiasedExp;

    assign prod.productSign = ops.signA ^ ops.signB;

    assign expSum      = ops.expA + ops.expB;
    assign rebiasedExp = expSum - productExpT'(expBias);

    // A zero input forces an all-zero product
    assign prod.productExp = ops.productInputZero ? '0 : rebiasedExp;
    assign prod.productSig = ops.productInputZero ? '0 : ops.sigA * ops.sigB;

    // Bit 5 is a borrow when the exponent sum was small, a carry when it was large
    assign prod.productExpNegative = prod.productExp[5] & ~expSum[5];
    assign prod.productExpOverflow = prod.productExp[5] & expSum[5];

endmodule

// ==== hw/accumulator.sv ====
// Accumulator stage
// Exponent alignment, sticky bits and signed significand add/subtract
`timescale 1ns/1ps

module accumulator import fmaPkg::*; (
    operandIf.datapath ops,
    productIf.reader   prod,
    sumIf.driver       sum
);
    logic [6:0]  expDiff;
    logic        cExpGreater;
    logic [6:0]  shiftA, shiftB;
    logic [41:0] shiftedProd, shiftedC;
    logic [21:0] alignedA, alignedB;
    logic [22:0] opA, opB;
    sumSigT      standardSum, invertedSum;
    logic        useInverted;

    // True when any bit of the padded operand drops below the kept window
    function automatic logic lostBits(input logic [41:0] padded, input logic [6:0] shiftAmt);
        logic [41:0] keepMask;
        keepMask = {42{1'b1}} << ({1'b0, shiftAmt} + 8'd20);
        return |(padded & ~keepMask);
    endfunction

    // Product exponent sign extended so a negative exponent aligns correctly
    assign expDiff     = {prod.productExpNegative, prod.productExp} - {2'b00, ops.expC};
    assign cExpGreater = expDiff[6] | prod.productExpNegative;

    assign shiftA = cExpGreater ? (7'd0 - expDiff) : 7'd0;
    assign shiftB = cExpGreater ? 7'd0 : expDiff;

    // Window [41:20] holds the aligned operand, lower bits are shifted out
    assign shiftedProd = {prod.productSig, 20'b0} >> shiftA;
    assign shiftedC    = {1'b0, ops.sigC, 30'b0} >> shiftB;

    assign alignedA = shiftedProd[41:20];
    assign alignedB = shiftedC[41:20];

    assign sum.stickyA = lostBits({prod.productSig, 20'b0}, shiftA);
    assign sum.stickyB = lostBits({1'b0, ops.sigC, 30'b0}, shiftB);

    assign opA = {alignedA, sum.stickyA};
    assign opB = {alignedB, sum.stickyB};

    assign sum.sumSubtraction = prod.productSign ^ ops.signC;

    assign standardSum = sum.sumSubtraction ? ({1'b0, opA} - {1'b0, opB})
                                            : ({1'b0, opA} + {1'b0, opB});
    assign invertedSum = {1'b0, opB} - {1'b0, opA};

    // Pick whichever difference is non-negative
    assign useInverted = sum.sumSubtraction & ~invertedSum[23];

    // An infinite or overflowed product keeps its own sign
    assign sum.sumSign = prod.productSign ^
                         (useInverted & ~ops.productOperandInf & ~prod.productExpOverflow);

    assign sum.sumExp = cExpGreater ? ops.expC : prod.productExp[4:0];
    assign sum.sumSig = useInverted ? invertedSum : standardSum;

endmodule

// ==== hw/normalizationShifter.sv ====
// Normalization shifter
// Leading-one search, shift into the hidden position and exponent adjust
`timescale 1ns/1ps

module normalizationShifter import fmaPkg::*; (
    sumIf.reader     sum,
    productIf.reader prod,
    output logic     normSign,
    output expT      normExp,
    output sumSigT   normSig,
    output logic     normOverflow
);
    logic       carryOut;
    logic       sumIsZero;
    logic [4:0] leadPos;
    logic [5:0] expAdjust;
    logic [5:0] expWide;

    // Bit 23 is a real carry only for an addition
    assign carryOut  = sum.sumSig[23] & ~sum.sumSubtraction;
    assign sumIsZero = ~carryOut & ~(|sum.sumSig[22:1]);

    // Priority search, highest set bit wins
    always_comb begin
        leadPos = 5'd0;
        for (int k = 1; k < 23; k++) begin
            if (sum.sumSig[k]) begin
                leadPos = 5'(k);
            end
        end
    end

    // Bit 21 is the hidden position at the unchanged exponent
    assign expAdjust = carryOut ? 6'd2 : ({1'b0, leadPos} - 6'd21);
    assign expWide   = {1'b0, sum.sumExp} + expAdjust;

    always_comb begin
        if (sumIsZero) begin
            normSign     = prod.productSign & prod.productExpNegative;
            normExp      = '0;
            normSig      = '0;
            normOverflow = 1'b0;
        end else begin
            normSign = sum.sumSign;
            normExp  = expWide[4:0];
            normSig  = carryOut ? sum.sumSig : (sum.sumSig << (5'd23 - leadPos));
            // A carry from a downward adjust is only a borrow
            normOverflow = (~expAdjust[5] & expWide[5]) | (expWide[4:0] == expAllOnes);
        end
    end

endmodule

// ==== hw/rounder.sv ====
// Rounder
// Round-up decision for all four modes, increment and overflow handling
`timescale 1ns/1ps

module rounder import fmaPkg::*; (
    input  roundModeT roundMode,
    input  logic      normSign,
    input  expT       normExp,
    input  sumSigT    normSig,
    input  logic      normOverflow,
    sumIf.reader      sum,
    productIf.reader  prod,
    output halfWordT  roundedWord,
    output logic      inexactRound,
    output logic      roundUpOverflow
);
    logic        lsb, guardBit, roundBit, stickyBit;
    logic        tailNonZero;
    logic        inexactTruncate;
    logic        preRoundOverflow;
    logic        incrementSig;
    logic [11:0] sigPlusOne;
    logic [5:0]  roundedExpWide;
    logic [9:0]  roundedMant;
    logic        overflowAfterRound;

    // Hidden bit sits at 23, mantissa at [22:13]
    assign lsb         = normSig[13];
    assign guardBit    = normSig[12];
    assign roundBit    = normSig[11];
    assign stickyBit   = |normSig[10:0];
    assign tailNonZero = guardBit | roundBit | stickyBit;

    // Alignment sticky bits only show up in the inexact flag
    assign inexactTruncate  = tailNonZero | sum.stickyA | sum.stickyB;
    assign preRoundOverflow = prod.productExpOverflow | normOverflow;

    always_comb begin
        case (roundMode)
            roundTowardZero:  incrementSig = 1'b0;
            roundNearestEven: incrementSig = preRoundOverflow |
                                             (guardBit & (lsb | roundBit | stickyBit));
            roundDown:        incrementSig = preRoundOverflow ? normSign
                                                              : (normSign & tailNonZero);
            roundUp:          incrementSig = preRoundOverflow ? ~normSign
                                                              : (~normSign & tailNonZero);
            default:          incrementSig = 1'b0;
        endcase
    end

    // Increment with renormalization on carry out of the significand
    assign sigPlusOne     = {1'b0, normSig[23:13]} + 12'd1;
    assign roundedExpWide = {1'b0, normExp} + {5'b0, sigPlusOne[11]};
    assign roundedMant    = sigPlusOne[11] ? sigPlusOne[10:1] : sigPlusOne[9:0];

    assign overflowAfterRound = roundedExpWide > {1'b0, maxFiniteExp};

    always_comb begin
        roundUpOverflow = 1'b0;
        if (preRoundOverflow) begin
            // Infinity when rounding away, largest finite number otherwise
            inexactRound = 1'b1;
            roundedWord  = incrementSig ? {normSign, infMagnitude[14:0]}
                                        : {normSign, maxFiniteMagnitude[14:0]};
        end else if (incrementSig) begin
            inexactRound = 1'b1;
            if (overflowAfterRound) begin
                roundUpOverflow = 1'b1;
                roundedWord     = {normSign, infMagnitude[14:0]};
            end else begin
                roundedWord = {normSign, roundedExpWide[4:0], roundedMant};
            end
        end else begin
            inexactRound = inexactTruncate;
            roundedWord  = {normSign, normExp, normSig[22:13]};
        end
    end

endmodule

// ==== hw/resultSelector.sv ====
// Result selector
// Special-case priority, flag assembly and the registered outputs
`timescale 1ns/1ps

module resultSelector import fmaPkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  halfWordT  roundedWord,
    input  logic      inexactRound,
    input  logic      roundUpOverflow,
    input  logic      normOverflow,
    operandIf.special ops,
    productIf.reader  prod,
    sumIf.reader      sum,
    output halfWordT  result,
    output flagsT     flags
);
    logic     zeroTimesInf;
    logic     anyNan;
    logic     invalidOp;
    logic     useRounded;
    halfWordT nextResult;
    flagsT    nextFlags;

    // Both conditions hold without a NaN only for zero times infinity
    assign zeroTimesInf = ops.productInputZero & ops.productOperandInf & ~ops.nanA & ~ops.nanB;
    assign anyNan       = ops.nanA | ops.nanB | ops.nanC;

    always_comb begin
        invalidOp  = 1'b0;
        useRounded = 1'b0;
        if (zeroTimesInf) begin
            nextResult = canonicalNan;
            invalidOp  = 1'b1;
        end else if (anyNan) begin
            nextResult = canonicalNan;
        end else if (ops.productOperandInf) begin
            // Opposite infinity in C cancels the infinite product
            if (ops.cIsInf & (sum.sumSubtraction | ops.cMantisaNonZero)) begin
                nextResult = canonicalNan;
                invalidOp  = ~ops.cMantisaNonZero;
            end else begin
                nextResult = {prod.productSign, infMagnitude[14:0]};
            end
        end else if (ops.cIsInf & ~ops.cMantisaNonZero) begin
            nextResult = {ops.signC, infMagnitude[14:0]};
        end else begin
            nextResult = roundedWord;
            useRounded = 1'b1;
        end
    end

    // Special results are exact, so only the rounded path reports overflow or inexact
    always_comb begin
        nextFlags                = '0;
        nextFlags[flagInvalid]   = ops.snanA | ops.snanB | ops.snanC | invalidOp;
        nextFlags[flagOverflow]  = useRounded &
                                   (prod.productExpOverflow | normOverflow | roundUpOverflow);
        nextFlags[flagUnderflow] = 1'b0;
        nextFlags[flagInexact]   = useRounded & (inexactRound | prod.productExpOverflow);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
            flags  <= '0;
        end else begin
            result <= nextResult;
            flags  <= nextFlags;
        end
    end

endmodule

// ==== hw/fma16.sv ====
// Half-precision fused multiply-add, result = A * B + C
// Combinational datapath with one output register
`timescale 1ns/1ps

module fma16 import fmaPkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  halfWordT  operandA,
    input  halfWordT  operandB,
    input  halfWordT  operandC,
    input  logic      mul,
    input  logic      add,
    input  roundModeT roundMode,
    output halfWordT  result,
    output flagsT     flags
);
    operandIf opsBus ();
    productIf prodBus ();
    sumIf     sumBus ();

    logic     normSign;
    expT      normExp;
    sumSigT   normSig;
    logic     normOverflow;

    halfWordT roundedWord;
    logic     inexactRound;
    logic     roundUpOverflow;

    operandDecoder uDecoder (
        .operandA, .operandB, .operandC, .mul, .add, .ops(opsBus)
    );

    multiplier uMultiplier (.ops(opsBus), .prod(prodBus));

    accumulator uAccumulator (.ops(opsBus), .prod(prodBus), .sum(sumBus));

    normalizationShifter uNormalizer (
        .sum(sumBus), .prod(prodBus), .normSign, .normExp, .normSig, .normOverflow
    );

    rounder uRounder (
        .roundMode, .normSign, .normExp, .normSig, .normOverflow,
        .sum(sumBus), .prod(prodBus), .roundedWord, .inexactRound, .roundUpOverflow
    );

    resultSelector uSelector (
        .clk, .reset, .roundedWord, .inexactRound, .roundUpOverflow, .normOverflow,
        .ops(opsBus), .prod(prodBus), .sum(sumBus), .result, .flags
    );

endmodule

// ==== verif/tbClock.sv ====
// Testbench clock and reset generator
// 20 ns clock, reset high across the first two rising edges
`timescale 1ns/1ps

module tbClock (
    output logic clk,
    output logic reset
);
    localparam int halfPeriod = 10;

    initial begin
        clk = 1'b0;
        forever #(halfPeriod) clk = ~clk;
    end

    // Rising edges at 10 and 30 ns, release 1 ns after the second one
    initial begin
        reset = 1'b1;
        #(3 * halfPeriod + 1);
        reset = 1'b0;
    end

endmodule

// ==== verif/fma16Tb.sv ====
// Testbench for the half-precision FMA
// Vector table, back-to-back apply loop, value check and timeouts
`timescale 1ns/1ps

module fma16Tb import fmaPkg::*; ();

    // Polling steps of 1 ns
    localparam int edgeTimeoutSteps  = 60;
    localparam int resetTimeoutSteps = 200;

    typedef struct packed {
        halfWordT  a;
        halfWordT  b;
        halfWordT  c;
        logic      mul;
        logic      add;
        roundModeT mode;
        halfWordT  expResult;
        flagsT     expFlags;
    } vectorRowT;

    logic      clk;
    logic      reset;
    halfWordT  operandA;
    halfWordT  operandB;
    halfWordT  operandC;
    logic      mul;
    logic      add;
    roundModeT roundMode;
    halfWordT  result;
    flagsT     flags;

    vectorRowT vectors[$];

    tbClock uClock (.clk, .reset);

    fma16 u_dut (
        .clk, .reset, .operandA, .operandB, .operandC,
        .mul, .add, .roundMode, .result, .flags
    );

    task automatic failRun(input string what);
        $display("%s", what);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic checkValue(input string name, input logic [15:0] actual,
                              input logic [15:0] expected);
        if (actual !== expected) begin
            failRun($sformatf("mismatch at %0t ns: %s is 0x%04h, expected 0x%04h",
                              $time, name, actual, expected));
        end
    endtask

    // Polls half a step off the integer grid, returns 1 ns after the edge
    task automatic waitRisingEdge(input string what);
        int   steps;
        logic prevClk;
        logic seen;
        steps = 0;
        seen  = 1'b0;
        #0.5;
        prevClk = clk;
        while (!seen && steps < edgeTimeoutSteps) begin
            #1;
            steps++;
            if (prevClk === 1'b0 && clk === 1'b1) begin
                seen = 1'b1;
            end
            prevClk = clk;
        end
        if (!seen) begin
            failRun($sformatf("timeout: no rising clock edge while waiting for %s", what));
        end
        #0.5;
    endtask

    task automatic waitResetRelease();
        int steps;
        steps = 0;
        #0.5;
        while (reset !== 1'b0 && steps < resetTimeoutSteps) begin
            #1;
            steps++;
        end
        if (reset !== 1'b0) begin
            failRun("timeout: reset was never released");
        end
        #0.5;
    endtask

    task automatic addRow(input halfWordT a, b, c, input logic mulEn, addEn,
                          input roundModeT mode, input halfWordT expResult,
                          input flagsT expFlags);
        vectors.push_back(vectorRowT'{a, b, c, mulEn, addEn, mode, expResult, expFlags});
    endtask

    task automatic loadTable();
        // Exact results, enables
        addRow(16'h3E00, 16'h4000, 16'h3800, 1'b1, 1'b1, roundNearestEven, 16'h4300, 4'b0000);
        addRow(16'h4200, 16'hC000, 16'h4B00, 1'b1, 1'b0, roundNearestEven, 16'hC600, 4'b0000);
        addRow(16'h3C00, 16'h4500, 16'h3C00, 1'b0, 1'b1, roundNearestEven, 16'h4000, 4'b0000);
        // Halfway between 0x3C00 and 0x3C01
        addRow(16'h3C00, 16'h3C00, 16'h1000, 1'b1, 1'b1, roundNearestEven, 16'h3C00, 4'b0001);
        addRow(16'h3C00, 16'h3C00, 16'h1000, 1'b1, 1'b1, roundTowardZero, 16'h3C00, 4'b0001);
        addRow(16'h3C00, 16'h3C00, 16'h1000, 1'b1, 1'b1, roundDown, 16'h3C00, 4'b0001);
        addRow(16'h3C00, 16'h3C00, 16'h1000, 1'b1, 1'b1, roundUp, 16'h3C01, 4'b0001);
        // Special cases
        addRow(16'h0000, 16'h7C00, 16'h0000, 1'b1, 1'b1, roundNearestEven, 16'h7E00, 4'b1000);
        addRow(16'h7E55, 16'h3C00, 16'h3C00, 1'b1, 1'b1, roundNearestEven, 16'h7E00, 4'b0000);
        addRow(16'h7C00, 16'h3C00, 16'hFC00, 1'b1, 1'b1, roundNearestEven, 16'h7E00, 4'b1000);
        addRow(16'h7C00, 16'h4000, 16'h3C00, 1'b1, 1'b1, roundNearestEven, 16'h7C00, 4'b0000);
        // Max finite times two
        addRow(16'h7BFF, 16'h4000, 16'h0000, 1'b1, 1'b1, roundNearestEven, 16'h7C00, 4'b0101);
        addRow(16'h7BFF, 16'h4000, 16'h0000, 1'b1, 1'b1, roundTowardZero, 16'h7BFF, 4'b0101);
    endtask

    task automatic applyRow(input vectorRowT row);
        operandA  = row.a;
        operandB  = row.b;
        operandC  = row.c;
        mul       = row.mul;
        add       = row.add;
        roundMode = row.mode;
    endtask

    initial begin
        // Idle inputs whose result and flags differ from the reset values
        operandA  = 16'h3C00;
        operandB  = 16'h3C00;
        operandC  = 16'h1000;
        mul       = 1'b1;
        add       = 1'b1;
        roundMode = roundNearestEven;
        loadTable();

        // Outputs cleared while reset is high
        waitRisingEdge("the first reset edge");
        checkValue("result", result, 16'h0000);
        checkValue("flags", 16'(flags), 16'h0000);
        waitRisingEdge("the second reset edge");
        checkValue("result", result, 16'h0000);
        checkValue("flags", 16'(flags), 16'h0000);

        waitResetRelease();
        checkValue("result", result, 16'h0000);
        checkValue("flags", 16'(flags), 16'h0000);
        waitRisingEdge("the first row slot");

        // One row per cycle, each checked one edge after it was applied
        for (int i = 0; i <= vectors.size(); i++) begin
            if (i < vectors.size()) begin
                applyRow(vectors[i]);
            end
            if (i > 0) begin
                checkValue($sformatf("result (row %0d)", i - 1), result,
                           vectors[i - 1].expResult);
                checkValue($sformatf("flags (row %0d)", i - 1), 16'(flags),
                           16'(vectors[i - 1].expFlags));
            end
            if (i < vectors.size()) begin
                waitRisingEdge($sformatf("the capture of row %0d", i));
            end
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== sources.f ====
hw/fmaPkg.sv
hw/fmaIfs.sv
hw/operandDecoder.sv
hw/multiplier.sv
hw/accumulator.sv
hw/normalizationShifter.sv
hw/rounder.sv
hw/resultSelector.sv
hw/fma16.sv
verif/tbClock.sv
verif/fma16Tb.sv

// ==== Makefile ====
# Verilator build and run for the half-precision FMA testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timescale 1ns/1ps --top-module fma16Tb -f sources.f \
		--Mdir obj_dir -o fma16Tb
	@out=$$(./obj_dir/fma16Tb 2>&1); echo "$$out"; echo "$$out" | grep -q "^TEST PASS$$"

clean:
	rm -rf obj_dir
